/* src/div_pkg.sv */
package div_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // radix 4 retires two quotient bits per step
    localparam int DIGIT_W = 2;
    localparam int NUM_STEPS = DATA_W / DIGIT_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [DIGIT_W-1:0] digit_t;

    // two extra bits so that three times the divisor fits
    typedef logic [DATA_W+DIGIT_W-1:0] rem_t;

    typedef logic [$clog2(NUM_STEPS+1)-1:0] step_t;

    typedef enum logic [1:0] {
        st_idle,
        st_prep,
        st_iterate,
        st_fix
    } ctrl_state_t;

endpackage

/* src/div_operand_if.sv */
interface div_operand_if;

    // magnitudes of the captured operands
    div_pkg::data_t abs_dividend;
    div_pkg::data_t abs_divisor;

    // sign correction for the final results
    logic neg_quotient;
    logic neg_remainder;

    modport prep (
        output abs_dividend,
        output abs_divisor,
        output neg_quotient,
        output neg_remainder
    );

    modport datapath (
        input abs_dividend,
        input abs_divisor
    );

    modport fix (
        input neg_quotient,
        input neg_remainder
    );

endinterface

/* src/div_ctrl.sv */
module div_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic capture,
    output logic load,
    output logic step,
    output logic fix
);

    div_pkg::ctrl_state_t state;
    div_pkg::ctrl_state_t state_next;
    div_pkg::step_t step_cnt;

    // only an idle controller accepts a request
    assign capture = (state == div_pkg::st_idle) && in_valid;
    assign load = (state == div_pkg::st_prep);
    assign step = (state == div_pkg::st_iterate);
    assign fix = (state == div_pkg::st_fix);

    always_comb begin
        state_next = state;
        case (state)
            div_pkg::st_idle: begin
                if (in_valid) begin
                    state_next = div_pkg::st_prep;
                end
            end
            div_pkg::st_prep: begin
                state_next = div_pkg::st_iterate;
            end
            div_pkg::st_iterate: begin
                // last digit step
                if (step_cnt == div_pkg::step_t'(div_pkg::NUM_STEPS - 1)) begin
                    state_next = div_pkg::st_fix;
                end
            end
            div_pkg::st_fix: begin
                state_next = div_pkg::st_idle;
            end
            default: begin
                state_next = div_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= div_pkg::st_idle;
            step_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == div_pkg::st_iterate) begin
                step_cnt <= step_cnt + 1'b1;
            end else begin
                step_cnt <= '0;
            end
        end
    end

endmodule

/* src/div_operand_prep.sv */
module div_operand_prep (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture,
    input  div_pkg::data_t      dividend,
    input  div_pkg::data_t      divisor,
    input  logic                is_signed,
    div_operand_if.prep         ops
);

    logic dividend_neg;
    logic divisor_neg;
    div_pkg::data_t dividend_mag;
    div_pkg::data_t divisor_mag;

    // sign bits only count in signed mode
    assign dividend_neg = is_signed && dividend[div_pkg::DATA_W-1];
    assign divisor_neg = is_signed && divisor[div_pkg::DATA_W-1];

    // two's complement magnitude
    // the most negative value maps onto itself and reads correctly as unsigned
    assign dividend_mag = dividend_neg ? (~dividend) + div_pkg::data_t'(1) : dividend;
    assign divisor_mag = divisor_neg ? (~divisor) + div_pkg::data_t'(1) : divisor;

    always_ff @(posedge clk) begin
        if (capture) begin
            ops.abs_dividend <= dividend_mag;
            ops.abs_divisor <= divisor_mag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ops.neg_quotient <= 1'b0;
            ops.neg_remainder <= 1'b0;
        end else if (capture) begin
            // quotient is negative when exactly one operand is
            ops.neg_quotient <= dividend_neg ^ divisor_neg;
            // remainder follows the dividend
            ops.neg_remainder <= dividend_neg;
        end
    end

endmodule

/* src/div_digit_select.sv */
module div_digit_select (
    input  div_pkg::rem_t   partial,
    input  div_pkg::data_t  divisor,
    output div_pkg::digit_t digit
);

    div_pkg::rem_t div_x1;
    div_pkg::rem_t div_x2;
    div_pkg::rem_t div_x3;

    assign div_x1 = div_pkg::rem_t'(divisor);
    assign div_x2 = div_x1 << 1;
    assign div_x3 = div_x1 + div_x2;

    // largest multiple that still fits under the partial remainder
    always_comb begin
        if (partial >= div_x3) begin
            digit = div_pkg::digit_t'(3);
        end else if (partial >= div_x2) begin
            digit = div_pkg::digit_t'(2);
        end else if (partial >= div_x1) begin
            digit = div_pkg::digit_t'(1);
        end else begin
            digit = div_pkg::digit_t'(0);
        end
    end

endmodule

/* src/div_iterate.sv */
module div_iterate (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            step,
    div_operand_if.datapath ops,
    output div_pkg::data_t  quotient_mag,
    output div_pkg::data_t  remainder_mag
);

    // remaining dividend bits in msb first order
    div_pkg::data_t dvd_sr;
    div_pkg::data_t partial;
    div_pkg::data_t quo;

    div_pkg::rem_t shifted;
    div_pkg::rem_t div_x1;
    div_pkg::rem_t multiple;
    div_pkg::digit_t digit;

    // bring down the next two dividend bits
    assign shifted = {partial, dvd_sr[div_pkg::DATA_W-1 -: div_pkg::DIGIT_W]};

    div_digit_select i_div_digit_select (
        .partial (shifted),
        .divisor (ops.abs_divisor),
        .digit   (digit)
    );

    assign div_x1 = div_pkg::rem_t'(ops.abs_divisor);

    // digit times divisor from shifts and one add
    always_comb begin
        case (digit)
            div_pkg::digit_t'(0): multiple = '0;
            div_pkg::digit_t'(1): multiple = div_x1;
            div_pkg::digit_t'(2): multiple = div_x1 << 1;
            default:              multiple = div_x1 + (div_x1 << 1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dvd_sr <= ops.abs_dividend;
        end else if (step) begin
            dvd_sr <= dvd_sr << div_pkg::DIGIT_W;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            partial <= '0;
            quo <= '0;
        end else if (load) begin
            partial <= '0;
            quo <= '0;
        end else if (step) begin
            // with a zero divisor the top two bits fall off here, which
            // leaves the dividend itself as remainder
            partial <= div_pkg::data_t'(shifted - multiple);
            quo <= {quo[div_pkg::DATA_W-div_pkg::DIGIT_W-1:0], digit};
        end
    end

    assign remainder_mag = partial;
    assign quotient_mag = quo;

endmodule

/* src/div_sign_fix.sv */
module div_sign_fix (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fix,
    input  div_pkg::data_t quotient_mag,
    input  div_pkg::data_t remainder_mag,
    div_operand_if.fix     ops,
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder,
    output logic           out_valid
);

    div_pkg::data_t quotient_adj;
    div_pkg::data_t remainder_adj;

    // negate where the operand signs call for it
    assign quotient_adj = ops.neg_quotient ?
                          (~quotient_mag) + div_pkg::data_t'(1) : quotient_mag;
    assign remainder_adj = ops.neg_remainder ?
                           (~remainder_mag) + div_pkg::data_t'(1) : remainder_mag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quotient <= '0;
            remainder <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= fix;
            // results hold until the next division finishes
            if (fix) begin
                quotient <= quotient_adj;
                remainder <= remainder_adj;
            end
        end
    end

endmodule

/* src/div_top.sv */
module div_top (
    input  logic           clk,
    input  logic           rst_n,
    input  div_pkg::data_t dividend,
    input  div_pkg::data_t divisor,
    input  logic           in_valid,
    input  logic           is_signed,
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder,
    output logic           out_valid
);

    logic capture;
    logic load;
    logic step;
    logic fix;

    div_pkg::data_t quotient_mag;
    div_pkg::data_t remainder_mag;

    // operand magnitudes and sign flags stay stable between captures
    div_operand_if ops ();

    div_ctrl i_div_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .capture  (capture),
        .load     (load),
        .step     (step),
        .fix      (fix)
    );

    div_operand_prep i_div_operand_prep (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .dividend  (dividend),
        .divisor   (divisor),
        .is_signed (is_signed),
        .ops       (ops.prep)
    );

    div_iterate i_div_iterate (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .step          (step),
        .ops           (ops.datapath),
        .quotient_mag  (quotient_mag),
        .remainder_mag (remainder_mag)
    );

    div_sign_fix i_div_sign_fix (
        .clk           (clk),
        .rst_n         (rst_n),
        .fix           (fix),
        .quotient_mag  (quotient_mag),
        .remainder_mag (remainder_mag),
        .ops           (ops.fix),
        .quotient      (quotient),
        .remainder     (remainder),
        .out_valid     (out_valid)
    );

endmodule

/* test/div_tb.sv */
module div_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    // edges from acceptance to the registered result
    localparam int LATENCY = 18;
    localparam int NUM_RANDOM = 200;
    // 8 + 200 unsigned, 9 + 200 signed, 7 by zero, 1 busy, 2 back to back
    localparam int NUM_REQUESTS = 427;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 20 + 200;
    localparam int QUIET_CYCLES = 25;
    localparam int RNG_SEED = 77858;

    logic clk;
    logic rst_n;
    div_pkg::data_t dividend;
    div_pkg::data_t divisor;
    logic in_valid;
    logic is_signed;
    div_pkg::data_t quotient;
    div_pkg::data_t remainder;
    logic out_valid;

    div_pkg::data_t rng_state;
    int checks_done;
    int cycle_count;

    div_top i_div_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .dividend  (dividend),
        .divisor   (divisor),
        .in_valid  (in_valid),
        .is_signed (is_signed),
        .quotient  (quotient),
        .remainder (remainder),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input div_pkg::data_t actual,
                               input div_pkg::data_t expected);
        checks_done++;
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0d ns: %s actual 0x%08h expected 0x%08h",
                                     $time, name, actual, expected));
        end
    endtask

    function automatic div_pkg::data_t xorshift32(input div_pkg::data_t x);
        div_pkg::data_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic div_pkg::data_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // expected results straight from the division rules
    task automatic reference_divide(input div_pkg::data_t a, input div_pkg::data_t b,
                                    input logic sgn, output div_pkg::data_t q,
                                    output div_pkg::data_t r);
        longint sa;
        longint sb;
        longint sq;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (b == '0) begin
            r = a;
            // unsigned gives all ones and signed gives one for a negative dividend
            if (sgn && a[31]) begin
                q = 32'd1;
            end else begin
                q = '1;
            end
        end else if (sgn) begin
            // 64 bits so that the most negative value over -1 does not overflow
            sq = sa / sb;
            q = div_pkg::data_t'(sq);
            r = div_pkg::data_t'(sa - sq * sb);
        end else begin
            q = a / b;
            r = a - q * b;
        end
    endtask

    // called right after a falling edge and returns one falling edge after acceptance
    task automatic issue_request(input div_pkg::data_t a, input div_pkg::data_t b,
                                 input logic sgn);
        dividend = a;
        divisor = b;
        is_signed = sgn;
        in_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_result(output int edges);
        edges = 0;
        while (out_valid !== 1'b1 && edges <= LATENCY + 4) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (out_valid !== 1'b1) begin
            report_failure("out_valid never rose after an accepted request");
        end
    endtask

    task automatic check_result(input div_pkg::data_t a, input div_pkg::data_t b,
                                input logic sgn, input int edges);
        div_pkg::data_t q_exp;
        div_pkg::data_t r_exp;
        reference_divide(a, b, sgn, q_exp, r_exp);
        check_value("out_valid latency", div_pkg::data_t'(edges), div_pkg::data_t'(LATENCY));
        check_value($sformatf("quotient of 0x%08h / 0x%08h signed=%0b", a, b, sgn),
                    quotient, q_exp);
        check_value($sformatf("remainder of 0x%08h / 0x%08h signed=%0b", a, b, sgn),
                    remainder, r_exp);
    endtask

    task automatic divide_and_check(input div_pkg::data_t a, input div_pkg::data_t b,
                                    input logic sgn);
        int edges;
        issue_request(a, b, sgn);
        wait_result(edges);
        check_result(a, b, sgn, edges);
        // the pulse lasts a single cycle
        @(negedge clk);
        check_value("out_valid", div_pkg::data_t'(out_valid), '0);
    endtask

    task automatic reset_values();
        repeat (2) begin
            check_value("out_valid", div_pkg::data_t'(out_valid), '0);
            check_value("quotient", quotient, '0);
            check_value("remainder", remainder, '0);
            @(negedge clk);
        end
    endtask

    task automatic unsigned_division();
        div_pkg::data_t dvd_list [8];
        div_pkg::data_t dvs_list [8];
        div_pkg::data_t a;
        div_pkg::data_t b;
        div_pkg::data_t shift;
        dvd_list = '{32'd100, 32'd7, 32'd0, 32'hFFFF_FFFF,
                     32'hFFFF_FFFF, 32'h8000_0000, 32'hDEAD_BEEF, 32'd12345678};
        dvs_list = '{32'd7, 32'd100, 32'd5, 32'd1,
                     32'hFFFF_FFFF, 32'd3, 32'h0000_1234, 32'h0001_0000};
        foreach (dvd_list[i]) begin
            divide_and_check(dvd_list[i], dvs_list[i], 1'b0);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = rand_word();
            b = rand_word();
            shift = rand_word() % 32;
            // vary the divisor size to spread the quotient lengths
            b = b >> shift;
            if (b == '0) begin
                b = 32'd1;
            end
            divide_and_check(a, b, 1'b0);
        end
    endtask

    task automatic signed_division();
        div_pkg::data_t dvd_list [9];
        div_pkg::data_t dvs_list [9];
        div_pkg::data_t a;
        div_pkg::data_t b;
        div_pkg::data_t shift;
        dvd_list = '{32'd100, div_pkg::data_t'(-100), 32'd100, div_pkg::data_t'(-100),
                     32'h8000_0000, 32'h8000_0000, div_pkg::data_t'(-1), 32'd7,
                     32'h7FFF_FFFF};
        dvs_list = '{32'd7, 32'd7, div_pkg::data_t'(-7), div_pkg::data_t'(-7),
                     div_pkg::data_t'(-1), 32'd1, 32'd2, div_pkg::data_t'(-100),
                     div_pkg::data_t'(-1)};
        foreach (dvd_list[i]) begin
            divide_and_check(dvd_list[i], dvs_list[i], 1'b1);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = rand_word();
            b = rand_word();
            shift = rand_word() % 32;
            // arithmetic shift keeps the divisor sign
            b = div_pkg::data_t'($signed(b) >>> shift);
            if (b == '0) begin
                b = 32'd1;
            end
            divide_and_check(a, b, 1'b1);
        end
    endtask

    task automatic zero_divisor();
        divide_and_check(32'd0, 32'd0, 1'b0);
        divide_and_check(32'd12345, 32'd0, 1'b0);
        divide_and_check(32'hFFFF_FFFF, 32'd0, 1'b0);
        divide_and_check(32'd12345, 32'd0, 1'b1);
        divide_and_check(div_pkg::data_t'(-12345), 32'd0, 1'b1);
        divide_and_check(32'd0, 32'd0, 1'b1);
        divide_and_check(32'h8000_0000, 32'd0, 1'b1);
    endtask

    task automatic busy_requests();
        div_pkg::data_t a;
        div_pkg::data_t b;
        int edges;
        a = div_pkg::data_t'(-1000003);
        b = 32'd977;
        issue_request(a, b, 1'b1);
        edges = 0;
        while (out_valid !== 1'b1 && edges <= LATENCY + 4) begin
            // stray requests with other operands while busy
            dividend = rand_word();
            divisor = rand_word() | 32'd1;
            is_signed = edges[0];
            in_valid = (edges % 3 != 2);
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        in_valid = 1'b0;
        if (out_valid !== 1'b1) begin
            report_failure("out_valid never rose while stray requests were applied");
        end
        check_result(a, b, 1'b1, edges);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("out_valid after busy requests", div_pkg::data_t'(out_valid), '0);
        end
    endtask

    task automatic back_to_back_request();
        div_pkg::data_t a0;
        div_pkg::data_t b0;
        div_pkg::data_t a1;
        div_pkg::data_t b1;
        int edges;
        a0 = 32'd5000;
        b0 = 32'd7;
        a1 = div_pkg::data_t'(-5000);
        b1 = 32'd7;
        issue_request(a0, b0, 1'b0);
        wait_result(edges);
        check_result(a0, b0, 1'b0, edges);
        // sampled on the edge that ends the out_valid cycle
        issue_request(a1, b1, 1'b1);
        check_value("out_valid", div_pkg::data_t'(out_valid), '0);
        wait_result(edges);
        check_result(a1, b1, 1'b1, edges);
        @(negedge clk);
        check_value("out_valid", div_pkg::data_t'(out_valid), '0);
    endtask

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("timeout after %0d cycles, the tests did not finish",
                                 cycle_count));
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        is_signed = 1'b0;
        dividend = '0;
        divisor = '0;
        checks_done = 0;
        rng_state = div_pkg::data_t'(RNG_SEED);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        unsigned_division();
        signed_division();
        zero_divisor();
        busy_requests();
        back_to_back_request();

        $display("%0d checks done", checks_done);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* compile.f */
src/div_pkg.sv
src/div_operand_if.sv
src/div_ctrl.sv
src/div_operand_prep.sv
src/div_digit_select.sv
src/div_iterate.sv
src/div_sign_fix.sv
src/div_top.sv
test/div_tb.sv
